/* hw/decodePkg.sv */
package decodePkg;

	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] regField_t;
	typedef logic [1:0] signCmp_t;
	typedef logic [1:0] nextPc_t;
	typedef logic [4:0] aluOp_t;
	typedef logic [1:0] extOp_t;
	typedef logic [2:0] memSize_t;
	typedef logic [1:0] destSel_t;
	typedef logic [2:0] resultSel_t;
	typedef logic [4:0] excCode_t;

	// Sign class of rs from the operand comparator
	localparam signCmp_t SIGN_ZERO = 2'b00;
	localparam signCmp_t SIGN_POS  = 2'b01;
	localparam signCmp_t SIGN_NEG  = 2'b10;

	localparam nextPc_t NPC_SEQ    = 2'b00;
	localparam nextPc_t NPC_BRANCH = 2'b01;
	localparam nextPc_t NPC_JUMP   = 2'b10;
	localparam nextPc_t NPC_REG    = 2'b11;

	localparam aluOp_t ALU_ADD  = 5'b00000;
	localparam aluOp_t ALU_SUB  = 5'b00001;
	localparam aluOp_t ALU_OR   = 5'b00010;
	localparam aluOp_t ALU_AND  = 5'b00011;
	localparam aluOp_t ALU_NOR  = 5'b00100;
	localparam aluOp_t ALU_XOR  = 5'b00101;
	localparam aluOp_t ALU_SLL  = 5'b00110;
	localparam aluOp_t ALU_SRL  = 5'b00111;
	localparam aluOp_t ALU_SRA  = 5'b01000;
	localparam aluOp_t ALU_SLT  = 5'b01001;
	localparam aluOp_t ALU_SLTU = 5'b01010;
	localparam aluOp_t ALU_ADDU = 5'b01100;
	localparam aluOp_t ALU_SUBU = 5'b10000;
	localparam aluOp_t ALU_NONE = 5'b11111;

	localparam extOp_t EXT_ZERO  = 2'b00;
	localparam extOp_t EXT_SIGN  = 2'b01;
	localparam extOp_t EXT_UPPER = 2'b10; // Immediate to the upper half

	localparam memSize_t MEM_SB  = 3'b000;
	localparam memSize_t MEM_SH  = 3'b001;
	localparam memSize_t MEM_SW  = 3'b010;
	localparam memSize_t MEM_LBU = 3'b011;
	localparam memSize_t MEM_LB  = 3'b100;
	localparam memSize_t MEM_LHU = 3'b101;
	localparam memSize_t MEM_LH  = 3'b110;
	localparam memSize_t MEM_LW  = 3'b111;

	localparam destSel_t DEST_RT = 2'b00;
	localparam destSel_t DEST_RD = 2'b01;
	localparam destSel_t DEST_RA = 2'b10; // Register 31

	localparam resultSel_t RES_IMM  = 3'b001;
	localparam resultSel_t RES_ALU  = 3'b010;
	localparam resultSel_t RES_LINK = 3'b011;
	localparam resultSel_t RES_MEM  = 3'b100;

	localparam excCode_t EXC_SYS = 5'd8;
	localparam excCode_t EXC_BP  = 5'd9;
	localparam excCode_t EXC_RI  = 5'd10;

	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_REGIMM  = 6'b000001;
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_JAL     = 6'b000011;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_BLEZ    = 6'b000110;
	localparam opcode_t OP_BGTZ    = 6'b000111;
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_SLTIU   = 6'b001011;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_BEQL    = 6'b010100;
	localparam opcode_t OP_BNEL    = 6'b010101;
	localparam opcode_t OP_BLEZL   = 6'b010110;
	localparam opcode_t OP_BGTZL   = 6'b010111;
	localparam opcode_t OP_LB      = 6'b100000;
	localparam opcode_t OP_LH      = 6'b100001;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_LBU     = 6'b100100;
	localparam opcode_t OP_LHU     = 6'b100101;
	localparam opcode_t OP_SB      = 6'b101000;
	localparam opcode_t OP_SH      = 6'b101001;
	localparam opcode_t OP_SW      = 6'b101011;

	localparam funct_t FN_SLL     = 6'b000000;
	localparam funct_t FN_SRL     = 6'b000010;
	localparam funct_t FN_SRA     = 6'b000011;
	localparam funct_t FN_SLLV    = 6'b000100;
	localparam funct_t FN_SRLV    = 6'b000110;
	localparam funct_t FN_SRAV    = 6'b000111;
	localparam funct_t FN_JR      = 6'b001000;
	localparam funct_t FN_JALR    = 6'b001001;
	localparam funct_t FN_SYSCALL = 6'b001100;
	localparam funct_t FN_BREAK   = 6'b001101;
	localparam funct_t FN_SYNC    = 6'b001111;
	localparam funct_t FN_ADD     = 6'b100000;
	localparam funct_t FN_ADDU    = 6'b100001;
	localparam funct_t FN_SUB     = 6'b100010;
	localparam funct_t FN_SUBU    = 6'b100011;
	localparam funct_t FN_AND     = 6'b100100;
	localparam funct_t FN_OR      = 6'b100101;
	localparam funct_t FN_XOR     = 6'b100110;
	localparam funct_t FN_NOR     = 6'b100111;
	localparam funct_t FN_SLT     = 6'b101010;
	localparam funct_t FN_SLTU    = 6'b101011;

	// REGIMM branch forms, bit 1 set marks the likely ones
	localparam regField_t RT_BLTZ    = 5'b00000;
	localparam regField_t RT_BGEZ    = 5'b00001;
	localparam regField_t RT_BLTZL   = 5'b00010;
	localparam regField_t RT_BGEZL   = 5'b00011;
	localparam regField_t RT_BLTZAL  = 5'b10000;
	localparam regField_t RT_BGEZAL  = 5'b10001;
	localparam regField_t RT_BLTZALL = 5'b10010;
	localparam regField_t RT_BGEZALL = 5'b10011;

endpackage

/* hw/branchDecode.sv */
`timescale 1ns/1ps

module branchDecode (
	input decodePkg::opcode_t op,
	input decodePkg::funct_t funct,
	input decodePkg::regField_t rt,
	input logic cmpNe,
	input decodePkg::signCmp_t cmpSign,
	output logic branchOp,
	output logic isBranch,
	output decodePkg::nextPc_t nextPc,
	output logic jump,
	output logic likelyFlush
);
	import decodePkg::*;

	logic condBranch; // Conditional branch recognized
	logic likely;
	logic taken; // Branch condition holds
	logic regJump; // JR or JALR
	logic immJump; // J or JAL
	logic rtZero;
	logic signNeg;
	logic signPos;

	assign rtZero = (rt == '0);
	assign signNeg = (cmpSign == SIGN_NEG);
	assign signPos = (cmpSign == SIGN_POS);
	assign regJump = (op == OP_SPECIAL) && (funct == FN_JR || funct == FN_JALR);
	assign immJump = (op == OP_J) || (op == OP_JAL);

	always_comb begin
		condBranch = 1'b1;
		likely = 1'b0;
		taken = 1'b0;
		case (op)
			OP_BEQ: taken = !cmpNe;
			OP_BNE: taken = cmpNe;
			OP_BLEZ: taken = !signPos;
			OP_BGTZ: taken = signPos;
			OP_BEQL: begin
				likely = 1'b1;
				taken = !cmpNe;
			end
			OP_BNEL: begin
				likely = 1'b1;
				taken = cmpNe;
			end
			// Likely blez/bgtz only exist with rt zero
			OP_BLEZL: begin
				condBranch = rtZero;
				likely = rtZero;
				taken = !signPos && rtZero;
			end
			OP_BGTZL: begin
				condBranch = rtZero;
				likely = rtZero;
				taken = signPos && rtZero;
			end
			OP_REGIMM: begin
				likely = rt[1];
				case (rt)
					RT_BGEZ, RT_BGEZL, RT_BGEZAL, RT_BGEZALL: taken = !signNeg;
					RT_BLTZ, RT_BLTZL, RT_BLTZAL, RT_BLTZALL: taken = signNeg;
					default: begin
						condBranch = 1'b0;
						likely = 1'b0;
					end
				endcase
			end
			default: condBranch = 1'b0;
		endcase
	end

	always_comb begin
		if (regJump)
			nextPc = NPC_REG;
		else if (immJump)
			nextPc = NPC_JUMP;
		else if (condBranch && taken)
			nextPc = NPC_BRANCH;
		else
			nextPc = NPC_SEQ;
	end

	assign branchOp = condBranch || regJump;
	assign isBranch = branchOp || immJump;
	assign jump = (nextPc != NPC_SEQ); // Redirect this cycle
	assign likelyFlush = likely && !taken; // Cancel the delay slot

endmodule

/* hw/aluDecode.sv */
`timescale 1ns/1ps

module aluDecode (
	input decodePkg::opcode_t op,
	input decodePkg::funct_t funct,
	input decodePkg::regField_t rt,
	output decodePkg::aluOp_t aluOp,
	output logic shiftByShamt,
	output decodePkg::extOp_t extOp,
	output logic immOperand
);
	import decodePkg::*;

	logic regimmForm; // rt names one of the REGIMM branches

	assign regimmForm = rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZL, RT_BGEZL,
		RT_BLTZAL, RT_BGEZAL, RT_BLTZALL, RT_BGEZALL};

	always_comb begin
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_ADDU: aluOp = ALU_ADDU;
					FN_SUB: aluOp = ALU_SUB;
					FN_SUBU: aluOp = ALU_SUBU;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_NOR: aluOp = ALU_NOR;
					FN_SLL, FN_SLLV: aluOp = ALU_SLL;
					FN_SRL, FN_SRLV: aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: aluOp = ALU_SRA;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					default: aluOp = ALU_NONE;
				endcase
			end
			OP_ADDI: aluOp = ALU_ADD;
			OP_ADDIU: aluOp = ALU_ADDU;
			OP_SLTI: aluOp = ALU_SLT;
			OP_SLTIU: aluOp = ALU_SLTU;
			OP_ANDI: aluOp = ALU_AND;
			OP_ORI: aluOp = ALU_OR;
			OP_XORI: aluOp = ALU_XOR;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
			OP_SB, OP_SH, OP_SW: aluOp = ALU_ADD; // Address calculation
			default: aluOp = ALU_NONE;
		endcase
	end

	// Fixed shift amount from the shamt field
	assign shiftByShamt = (op == OP_SPECIAL) &&
		(funct == FN_SLL || funct == FN_SRL || funct == FN_SRA);

	always_comb begin
		case (op)
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: extOp = EXT_SIGN;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
			OP_SB, OP_SH, OP_SW: extOp = EXT_SIGN;
			OP_ANDI, OP_ORI, OP_XORI: extOp = EXT_ZERO;
			OP_LUI: extOp = EXT_UPPER;
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
			OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL: extOp = EXT_SIGN; // Branch offset
			OP_REGIMM: extOp = regimmForm ? EXT_SIGN : EXT_ZERO;
			default: extOp = EXT_ZERO;
		endcase
	end

	assign immOperand = (op != OP_SPECIAL);

endmodule

/* hw/memDecode.sv */
`timescale 1ns/1ps

module memDecode (
	input decodePkg::opcode_t op,
	output logic memRead,
	output logic memWrite,
	output decodePkg::memSize_t memSize
);
	import decodePkg::*;

	always_comb begin
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = MEM_LW;
		case (op)
			OP_LB: begin
				memRead = 1'b1;
				memSize = MEM_LB;
			end
			OP_LBU: begin
				memRead = 1'b1;
				memSize = MEM_LBU;
			end
			OP_LH: begin
				memRead = 1'b1;
				memSize = MEM_LH;
			end
			OP_LHU: begin
				memRead = 1'b1;
				memSize = MEM_LHU;
			end
			OP_LW: memRead = 1'b1; // Size stays at the default
			OP_SB: begin
				memWrite = 1'b1;
				memSize = MEM_SB;
			end
			OP_SH: begin
				memWrite = 1'b1;
				memSize = MEM_SH;
			end
			OP_SW: begin
				memWrite = 1'b1;
				memSize = MEM_SW;
			end
			default: memSize = MEM_LW;
		endcase
	end

endmodule

/* hw/writebackDecode.sv */
`timescale 1ns/1ps

module writebackDecode (
	input decodePkg::opcode_t op,
	input decodePkg::funct_t funct,
	input decodePkg::regField_t rt,
	output logic regWrite,
	output decodePkg::destSel_t destSel,
	output decodePkg::resultSel_t resultSel
);
	import decodePkg::*;

	always_comb begin
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
					FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLL, FN_SRL, FN_SRA,
					FN_SLLV, FN_SRLV, FN_SRAV,
					FN_SLT, FN_SLTU: regWrite = 1'b1;
					FN_JALR: regWrite = 1'b1; // Link into rd
					default: regWrite = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: regWrite = 1'b1;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: regWrite = 1'b1;
			OP_JAL: regWrite = 1'b1;
			OP_REGIMM: begin
				// Only the linking forms write ra
				case (rt)
					RT_BLTZAL, RT_BGEZAL,
					RT_BLTZALL, RT_BGEZALL: regWrite = 1'b1;
					default: regWrite = 1'b0;
				endcase
			end
			default: regWrite = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			OP_SPECIAL: destSel = DEST_RD;
			OP_JAL, OP_REGIMM: destSel = DEST_RA;
			default: destSel = DEST_RT;
		endcase
	end

	always_comb begin
		case (op)
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: resultSel = RES_MEM;
			OP_LUI: resultSel = RES_IMM;
			OP_JAL, OP_REGIMM: resultSel = RES_LINK; // Return address
			OP_SPECIAL: resultSel = (funct == FN_JALR) ? RES_LINK : RES_ALU;
			default: resultSel = RES_ALU;
		endcase
	end

endmodule

/* hw/exceptionDecode.sv */
`timescale 1ns/1ps

module exceptionDecode (
	input logic clk,
	input logic rst,
	input decodePkg::opcode_t op,
	input decodePkg::funct_t funct,
	input logic regWrite,
	input logic memWrite,
	input logic branchOp,
	input logic excIn,
	input decodePkg::excCode_t excCodeIn,
	input logic ifFlush,
	output logic exception,
	output decodePkg::excCode_t excCode
);
	import decodePkg::*;

	logic resetState; // High through reset until the first edge after it
	logic recognized;
	logic isBreak;
	logic isSyscall;
	logic isSync;

	always_ff @(posedge clk) begin
		if (!rst)
			resetState <= 1'b1;
		else
			resetState <= 1'b0;
	end

	assign isBreak = (op == OP_SPECIAL) && (funct == FN_BREAK);
	assign isSyscall = (op == OP_SPECIAL) && (funct == FN_SYSCALL);
	assign isSync = (op == OP_SPECIAL) && (funct == FN_SYNC);

	// Instructions that write nothing still count once named here
	assign recognized = regWrite || memWrite || branchOp || (op == OP_J) ||
		(op == OP_JAL) || isBreak || isSyscall || isSync;

	always_comb begin
		exception = 1'b1;
		if (excIn)
			excCode = excCodeIn; // Fetch fault wins
		else if (!recognized && !resetState && !ifFlush)
			excCode = EXC_RI;
		else if (isBreak)
			excCode = EXC_BP;
		else if (isSyscall)
			excCode = EXC_SYS;
		else begin
			exception = 1'b0;
			excCode = '0;
		end
	end

endmodule

/* hw/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
	input logic clk,
	input logic rst,
	input decodePkg::opcode_t op,
	input decodePkg::funct_t funct,
	input decodePkg::regField_t rt,
	input logic cmpNe,
	input decodePkg::signCmp_t cmpSign,
	input logic excIn,
	input decodePkg::excCode_t excCodeIn,
	input logic ifFlush,
	output logic isBranch,
	output decodePkg::nextPc_t nextPc,
	output logic jump,
	output logic likelyFlush,
	output decodePkg::aluOp_t aluOp,
	output logic shiftByShamt,
	output decodePkg::extOp_t extOp,
	output logic immOperand,
	output logic memRead,
	output logic memWrite,
	output decodePkg::memSize_t memSize,
	output logic regWrite,
	output decodePkg::destSel_t destSel,
	output decodePkg::resultSel_t resultSel,
	output logic exception,
	output decodePkg::excCode_t excCode
);

	logic branchOp; // Branch or register jump, feeds the RI check

	branchDecode uBranch (
		.op(op),
		.funct(funct),
		.rt(rt),
		.cmpNe(cmpNe),
		.cmpSign(cmpSign),
		.branchOp(branchOp),
		.isBranch(isBranch),
		.nextPc(nextPc),
		.jump(jump),
		.likelyFlush(likelyFlush)
	);

	aluDecode uAlu (
		.op(op),
		.funct(funct),
		.rt(rt),
		.aluOp(aluOp),
		.shiftByShamt(shiftByShamt),
		.extOp(extOp),
		.immOperand(immOperand)
	);

	memDecode uMem (
		.op(op),
		.memRead(memRead),
		.memWrite(memWrite),
		.memSize(memSize)
	);

	writebackDecode uWriteback (
		.op(op),
		.funct(funct),
		.rt(rt),
		.regWrite(regWrite),
		.destSel(destSel),
		.resultSel(resultSel)
	);

	exceptionDecode uException (
		.clk(clk),
		.rst(rst),
		.op(op),
		.funct(funct),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.branchOp(branchOp),
		.excIn(excIn),
		.excCodeIn(excCodeIn),
		.ifFlush(ifFlush),
		.exception(exception),
		.excCode(excCode)
	);

endmodule

/* testbench/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rst
);
	localparam int PERIOD = 40;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = !clk;
	end

	initial begin
		rst = 1'b0; // Low across three rising edges
		#(3 * PERIOD) rst = 1'b1;
	end

endmodule

/* testbench/instrDecode_assert.sv */
`timescale 1ns/1ps

module instrDecodeAssert (
	input logic clk,
	input logic rst,
	input decodePkg::opcode_t op,
	input decodePkg::funct_t funct,
	input decodePkg::regField_t rt,
	input logic cmpNe,
	input decodePkg::signCmp_t cmpSign,
	input logic excIn,
	input decodePkg::excCode_t excCodeIn,
	input logic ifFlush,
	input logic isBranch,
	input decodePkg::nextPc_t nextPc,
	input logic jump,
	input logic likelyFlush,
	input decodePkg::aluOp_t aluOp,
	input logic shiftByShamt,
	input decodePkg::extOp_t extOp,
	input logic immOperand,
	input logic memRead,
	input logic memWrite,
	input decodePkg::memSize_t memSize,
	input logic regWrite,
	input decodePkg::destSel_t destSel,
	input decodePkg::resultSel_t resultSel,
	input logic exception,
	input decodePkg::excCode_t excCode
);
	import decodePkg::*;

	int failCount = 0; // Polled by the testbench
	logic armed = 1'b0; // First edge has no defined reset flag yet
	logic inReset = 1'b1;
	logic rJump;
	logic loadOp;
	logic storeOp;
	logic likelyForm;
	logic linkForm;
	logic condForm;
	logic condOk;
	logic writes;
	logic known;
	logic excOn;
	logic extChecked;
	logic branchExp;
	logic shamtExp;
	logic immExp;
	nextPc_t npcExp;
	aluOp_t aluExp;
	extOp_t extExp;
	memSize_t memExp;
	destSel_t destExp;
	resultSel_t resultExp;
	excCode_t excExp;

	always @(posedge clk) begin
		armed <= 1'b1;
		inReset <= !rst; // Mirrors the decode-stage reset flag
	end

	always_comb begin
		rJump = (op == OP_SPECIAL) && (funct == FN_JR || funct == FN_JALR);
		loadOp = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		storeOp = op inside {OP_SB, OP_SH, OP_SW};
		likelyForm = (op inside {OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL}) || ((op == OP_REGIMM) &&
			(rt inside {RT_BLTZL, RT_BGEZL, RT_BLTZALL, RT_BGEZALL}));
		linkForm = (op == OP_REGIMM) &&
			(rt inside {RT_BLTZAL, RT_BGEZAL, RT_BLTZALL, RT_BGEZALL});
		condForm = 1'b1;
		condOk = 1'b0;
		case (op)
			OP_BEQ, OP_BEQL: condOk = !cmpNe;
			OP_BNE, OP_BNEL: condOk = cmpNe;
			OP_BLEZ: condOk = (cmpSign != SIGN_POS);
			OP_BGTZ: condOk = (cmpSign == SIGN_POS);
			OP_BLEZL: begin
				condForm = (rt == '0);
				condOk = (cmpSign != SIGN_POS);
			end
			OP_BGTZL: begin
				condForm = (rt == '0);
				condOk = (cmpSign == SIGN_POS);
			end
			OP_REGIMM: begin
				condForm = likelyForm || linkForm || (rt inside {RT_BLTZ, RT_BGEZ});
				if (rt inside {RT_BGEZ, RT_BGEZL, RT_BGEZAL, RT_BGEZALL})
					condOk = (cmpSign != SIGN_NEG);
				else
					condOk = (cmpSign == SIGN_NEG);
			end
			default: condForm = 1'b0;
		endcase
		if (rJump)
			npcExp = NPC_REG;
		else if (op == OP_J || op == OP_JAL)
			npcExp = NPC_JUMP;
		else if (condForm && condOk)
			npcExp = NPC_BRANCH;
		else
			npcExp = NPC_SEQ;
		branchExp = condForm || rJump || op == OP_J || op == OP_JAL;
	end

	always_comb begin
		case (op)
			OP_SPECIAL: begin
				case (funct)
					FN_ADD: aluExp = ALU_ADD;
					FN_ADDU: aluExp = ALU_ADDU;
					FN_SUB: aluExp = ALU_SUB;
					FN_SUBU: aluExp = ALU_SUBU;
					FN_AND: aluExp = ALU_AND;
					FN_OR: aluExp = ALU_OR;
					FN_XOR: aluExp = ALU_XOR;
					FN_NOR: aluExp = ALU_NOR;
					FN_SLL, FN_SLLV: aluExp = ALU_SLL;
					FN_SRL, FN_SRLV: aluExp = ALU_SRL;
					FN_SRA, FN_SRAV: aluExp = ALU_SRA;
					FN_SLT: aluExp = ALU_SLT;
					FN_SLTU: aluExp = ALU_SLTU;
					default: aluExp = ALU_NONE;
				endcase
			end
			OP_ADDI: aluExp = ALU_ADD;
			OP_ADDIU: aluExp = ALU_ADDU;
			OP_SLTI: aluExp = ALU_SLT;
			OP_SLTIU: aluExp = ALU_SLTU;
			OP_ANDI: aluExp = ALU_AND;
			OP_ORI: aluExp = ALU_OR;
			OP_XORI: aluExp = ALU_XOR;
			default: aluExp = (loadOp || storeOp) ? ALU_ADD : ALU_NONE;
		endcase
		shamtExp = (op == OP_SPECIAL) && (funct inside {FN_SLL, FN_SRL, FN_SRA});
		immExp = (op != OP_SPECIAL);
		extChecked = 1'b1;
		if (loadOp || storeOp || (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}))
			extExp = EXT_SIGN;
		else if (op == OP_LUI)
			extExp = EXT_UPPER;
		else begin
			extChecked = (op inside {OP_ANDI, OP_ORI, OP_XORI});
			extExp = EXT_ZERO;
		end
		case (op)
			OP_LB: memExp = MEM_LB;
			OP_LBU: memExp = MEM_LBU;
			OP_LH: memExp = MEM_LH;
			OP_LHU: memExp = MEM_LHU;
			OP_SB: memExp = MEM_SB;
			OP_SH: memExp = MEM_SH;
			OP_SW: memExp = MEM_SW;
			default: memExp = MEM_LW;
		endcase
	end

	always_comb begin
		writes = loadOp || linkForm || (op == OP_JAL) ||
			(op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) ||
			((op == OP_SPECIAL) && (aluExp != ALU_NONE || funct == FN_JALR));
		if (op == OP_SPECIAL)
			destExp = DEST_RD;
		else if (op == OP_JAL || op == OP_REGIMM)
			destExp = DEST_RA;
		else
			destExp = DEST_RT;
		if (loadOp)
			resultExp = RES_MEM;
		else if (op == OP_LUI)
			resultExp = RES_IMM;
		else if (op == OP_JAL || op == OP_REGIMM || (op == OP_SPECIAL && funct == FN_JALR))
			resultExp = RES_LINK;
		else
			resultExp = RES_ALU;
		known = writes || storeOp || condForm || rJump || op == OP_J || op == OP_JAL ||
			((op == OP_SPECIAL) && (funct inside {FN_BREAK, FN_SYSCALL, FN_SYNC}));
		excOn = 1'b1;
		if (excIn)
			excExp = excCodeIn; // Upstream fault first
		else if (!known && !inReset && !ifFlush)
			excExp = EXC_RI;
		else if (op == OP_SPECIAL && funct == FN_BREAK)
			excExp = EXC_BP;
		else if (op == OP_SPECIAL && funct == FN_SYSCALL)
			excExp = EXC_SYS;
		else begin
			excOn = 1'b0;
			excExp = '0;
		end
	end

	aluCheck: assert property (@(posedge clk) armed |-> aluOp == aluExp)
		else begin
			failCount++;
			$error("[FAIL] %0t aluOp got %0h expected %0h", $time, aluOp, $sampled(aluExp));
		end

	extCheck: assert property (@(posedge clk) armed && extChecked |-> extOp == extExp)
		else begin
			failCount++;
			$error("[FAIL] %0t extOp got %0h expected %0h", $time, extOp, $sampled(extExp));
		end

	operandCheck: assert property (@(posedge clk)
		armed |-> {isBranch, shiftByShamt, immOperand} == {branchExp, shamtExp, immExp})
		else begin
			failCount++;
			$error("[FAIL] %0t isBranch/shiftByShamt/immOperand got %b expected %b", $time,
				$sampled({isBranch, shiftByShamt, immOperand}),
				$sampled({branchExp, shamtExp, immExp}));
		end

	memCheck: assert property (@(posedge clk)
		armed |-> {memRead, memWrite, memSize} == {loadOp, storeOp, memExp})
		else begin
			failCount++;
			$error("[FAIL] %0t memRead/memWrite/memSize got %b expected %b", $time,
				{memRead, memWrite, memSize}, $sampled({loadOp, storeOp, memExp}));
		end

	wbCheck: assert property (@(posedge clk)
		armed |-> {regWrite, destSel, resultSel} == {writes, destExp, resultExp})
		else begin
			failCount++;
			$error("[FAIL] %0t regWrite/destSel/resultSel got %b expected %b", $time,
				{regWrite, destSel, resultSel}, $sampled({writes, destExp, resultExp}));
		end

	branchCheck: assert property (@(posedge clk) armed |->
		{nextPc, jump, likelyFlush} == {npcExp, npcExp != NPC_SEQ, condForm && likelyForm && !condOk})
		else begin
			failCount++;
			$error("[FAIL] %0t nextPc/jump/likelyFlush got %b expected %b", $time,
				{nextPc, jump, likelyFlush},
				$sampled({npcExp, npcExp != NPC_SEQ, condForm && likelyForm && !condOk}));
		end

	excCheck: assert property (@(posedge clk) armed |-> {exception, excCode} == {excOn, excExp})
		else begin
			failCount++;
			$error("[FAIL] %0t exception/excCode got %b expected %b", $time,
				$sampled({exception, excCode}), $sampled({excOn, excExp}));
		end

	// Reserved instruction stays masked for the whole reset
	resetMaskCheck: assert property (@(posedge clk)
		armed && !rst && !excIn |-> !(exception && excCode == EXC_RI))
		else begin
			failCount++;
			$error("Reserved instruction exception raised while reset was asserted");
		end

endmodule

bind instrDecode instrDecodeAssert chk (.*);

/* testbench/instrDecodeTb.sv */
`timescale 1ns/1ps

module instrDecodeTb;
	import decodePkg::*;

	localparam logic [15:0] LFSR_SEED = 16'd63737;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_INSTR = 600;
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst;
	opcode_t op;
	funct_t funct;
	regField_t rt;
	logic cmpNe;
	signCmp_t cmpSign;
	logic excIn;
	excCode_t excCodeIn;
	logic ifFlush;
	logic isBranch;
	nextPc_t nextPc;
	logic jump;
	logic likelyFlush;
	aluOp_t aluOp;
	logic shiftByShamt;
	extOp_t extOp;
	logic immOperand;
	logic memRead;
	logic memWrite;
	memSize_t memSize;
	logic regWrite;
	destSel_t destSel;
	resultSel_t resultSel;
	logic exception;
	excCode_t excCode;
	logic [15:0] lfsr;

	// Kept instructions, grouped by the field that selects them
	opcode_t opTable[$] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL,
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
	funct_t functTable[$] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
		FN_JR, FN_JALR, FN_SYSCALL, FN_BREAK, FN_SYNC, FN_ADD, FN_ADDU, FN_SUB,
		FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
	regField_t rtTable[$] = '{RT_BLTZ, RT_BGEZ, RT_BLTZL, RT_BGEZL,
		RT_BLTZAL, RT_BGEZAL, RT_BLTZALL, RT_BGEZALL};
	signCmp_t signTable[$] = '{SIGN_ZERO, SIGN_POS, SIGN_NEG};

	tbClock clockGen (
		.clk(clk),
		.rst(rst)
	);

	instrDecode DUT (.*);

	function automatic logic stepLfsr();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ LFSR_TAPS; // Galois feedback
		return outBit;
	endfunction

	function automatic int randBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++)
			value = (value << 1) | int'(stepLfsr());
		return value;
	endfunction

	task automatic stopWithFailure(input string why);
		$display("Finished with errors");
		$fatal(1, why);
	endtask

	task automatic checkFailures();
		if (DUT.chk.failCount != 0)
			stopWithFailure("An assertion on the decode outputs failed");
	endtask

	// Opcode outside the kept set, with nothing upstream to hide it
	task automatic driveReserved();
		op = opcode_t'(6'b111111);
		excIn = 1'b0;
		ifFlush = 1'b0;
	endtask

	task automatic driveInstr();
		int pick;
		pick = randBits(3);
		funct = funct_t'(randBits(6));
		rt = regField_t'(randBits(5));
		if (pick == 0) begin
			op = opcode_t'(randBits(6)); // Any opcode, kept or not
		end else if (pick < 3) begin
			op = OP_SPECIAL;
			funct = functTable[randBits(5) % functTable.size()];
		end else if (pick == 3) begin
			op = OP_REGIMM;
			rt = rtTable[randBits(3) % rtTable.size()];
		end else begin
			op = opTable[randBits(5) % opTable.size()];
			if (stepLfsr())
				rt = '0; // Lets BLEZL and BGTZL decode
		end
		cmpNe = stepLfsr();
		cmpSign = signTable[randBits(2) % signTable.size()];
		excIn = (randBits(3) == 0);
		excCodeIn = excCode_t'(randBits(5));
		ifFlush = (randBits(3) == 0);
	endtask

	initial begin : watchdog
		for (int cycle = 0; cycle < TIMEOUT_CYCLES; cycle++)
			#(CLK_PERIOD);
		stopWithFailure("The run did not finish before the timeout");
	end

	initial begin
		int sent;
		int cycles;
		lfsr = LFSR_SEED;
		op = OP_SPECIAL;
		funct = FN_SLL;
		rt = '0;
		cmpNe = 1'b0;
		cmpSign = SIGN_ZERO;
		excIn = 1'b0;
		excCodeIn = '0;
		ifFlush = 1'b0;
		sent = 0;
		cycles = 0;
		while (sent < NUM_INSTR && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			checkFailures();
			if (cycles <= RESET_CYCLES)
				driveReserved(); // Sampled while the reset flag is still set
			else
				driveInstr();
			sent++;
		end
		@(negedge clk); // Last instruction sampled at the edge before
		if (sent < NUM_INSTR)
			stopWithFailure("Not all instructions were sent before the timeout");
		else if (DUT.chk.failCount != 0)
			stopWithFailure("An assertion on the decode outputs failed");
		else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* verilog.f */
hw/decodePkg.sv
hw/branchDecode.sv
hw/aluDecode.sv
hw/memDecode.sv
hw/writebackDecode.sv
hw/exceptionDecode.sv
hw/instrDecode.sv
testbench/tbClock.sv
testbench/instrDecode_assert.sv
testbench/instrDecodeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module instrDecodeTb -f verilog.f \
	&& ./obj_dir/VinstrDecodeTb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
